//--- verilog/dzcpuPkg.sv
package dzcpuPkg;

	localparam int DataWidth  = 8;
	localparam int AddrWidth  = 16;
	localparam int UaddrWidth = 7;

	//////////////////////////////////////////////////
	// Micro-op fields

	// Flow control, decides PC advance and end of flow
	typedef enum logic [2:0]
	{
		flowOp,
		flowInc,
		flowEof,
		flowIncEof,
		flowIncEofZ,
		flowIncEofNz,
		flowUpdateFlags
	} uFlow_t;

	typedef enum logic [3:0]
	{
		opNop,
		opSma,
		opSmw,
		opSrm,
		opSx16r,
		opSrx16,
		opAddx16,
		opSubx16,
		opInc16,
		opDec16,
		opSpc
	} uOp_t;

	// Operand select, HL and PC are the 16-bit ones
	typedef enum logic [3:0]
	{
		rA,
		rB,
		rC,
		rH,
		rL,
		rHL,
		rPC,
		rX8,
		rX16,
		rNull
	} uOperand_t;

	typedef enum logic
	{
		seqFetch,
		seqExec
	} seqState_t;

	//////////////////////////////////////////////////
	// Flow start addresses in the micro-op ROM

	localparam logic [UaddrWidth-1:0] flowNop    = 7'd0;
	localparam logic [UaddrWidth-1:0] flowLdBn   = 7'd1;
	localparam logic [UaddrWidth-1:0] flowLdCn   = 7'd5;
	localparam logic [UaddrWidth-1:0] flowLdAn   = 7'd9;
	localparam logic [UaddrWidth-1:0] flowLdHLnn = 7'd13;
	localparam logic [UaddrWidth-1:0] flowIncB   = 7'd20;
	localparam logic [UaddrWidth-1:0] flowDecB   = 7'd22;
	localparam logic [UaddrWidth-1:0] flowAddAB  = 7'd24;
	localparam logic [UaddrWidth-1:0] flowSubB   = 7'd27;
	localparam logic [UaddrWidth-1:0] flowLdHLmA = 7'd30;
	localparam logic [UaddrWidth-1:0] flowLdHLmB = 7'd32;
	localparam logic [UaddrWidth-1:0] flowLdAHLm = 7'd34;
	localparam logic [UaddrWidth-1:0] flowJr     = 7'd37;
	localparam logic [UaddrWidth-1:0] flowJrNz   = 7'd44;
	localparam logic [UaddrWidth-1:0] flowJrZ    = 7'd51;

endpackage

//--- verilog/dzcpuUopIf.sv
`timescale 1ns/1ps

interface dzcpuUopIf
	import dzcpuPkg::*;
();
	// Current micro-op word
	uFlow_t    flow;
	uOp_t      op;
	uOperand_t operand;

	logic      exec;
	logic      fetch;

	// Fed back for the conditional exits
	logic      flagZ;

	modport seq
	(
		output flow, op, operand, exec, fetch,
		input  flagZ
	);

	modport dp
	(
		input  flow, op, operand, exec, fetch,
		output flagZ
	);

endinterface

//--- verilog/dzcpuOpcodeLut.sv
`timescale 1ns/1ps

module dzcpuOpcodeLut
	import dzcpuPkg::*;
(
	input  logic [DataWidth-1:0]  opcode,
	output logic [UaddrWidth-1:0] flowStart
);

	always_comb
	begin
		case (opcode)
			8'h00: flowStart = flowNop;

			// 8-bit and 16-bit immediates
			8'h06: flowStart = flowLdBn;
			8'h0E: flowStart = flowLdCn;
			8'h3E: flowStart = flowLdAn;
			8'h21: flowStart = flowLdHLnn;

			// ALU
			8'h04: flowStart = flowIncB;
			8'h05: flowStart = flowDecB;
			8'h80: flowStart = flowAddAB;
			8'h90: flowStart = flowSubB;

			// Memory through HL
			8'h77: flowStart = flowLdHLmA;
			8'h70: flowStart = flowLdHLmB;
			8'h7E: flowStart = flowLdAHLm;

			// Relative jumps
			8'h18: flowStart = flowJr;
			8'h20: flowStart = flowJrNz;
			8'h28: flowStart = flowJrZ;

			// anything unsupported behaves as NOP
			default: flowStart = flowNop;
		endcase
	end

endmodule

//--- verilog/dzcpuUcodeRom.sv
`timescale 1ns/1ps

module dzcpuUcodeRom
	import dzcpuPkg::*;
(
	input  logic [UaddrWidth-1:0] addr,
	output uFlow_t                flow,
	output uOp_t                  op,
	output uOperand_t             operand
);

	typedef struct packed
	{
		uFlow_t    flow;
		uOp_t      op;
		uOperand_t operand;
	} uWord_t;

	uWord_t word;

	always_comb
	begin
		case (addr)
			flowNop:            word = '{flowIncEof, opNop, rNull};
			//////////////////////////////////////////////////
			// Immediate loads, operand read one cycle after sma
			flowLdBn:           word = '{flowInc, opNop, rNull};
			flowLdBn + 7'd1:    word = '{flowOp, opSma, rPC};
			flowLdBn + 7'd2:    word = '{flowOp, opNop, rNull};
			flowLdBn + 7'd3:    word = '{flowIncEof, opSrm, rB};
			flowLdCn:           word = '{flowInc, opNop, rNull};
			flowLdCn + 7'd1:    word = '{flowOp, opSma, rPC};
			flowLdCn + 7'd2:    word = '{flowOp, opNop, rNull};
			flowLdCn + 7'd3:    word = '{flowIncEof, opSrm, rC};
			flowLdAn:           word = '{flowInc, opNop, rNull};
			flowLdAn + 7'd1:    word = '{flowOp, opSma, rPC};
			flowLdAn + 7'd2:    word = '{flowOp, opNop, rNull};
			flowLdAn + 7'd3:    word = '{flowIncEof, opSrm, rA};
			// Low byte first
			flowLdHLnn:         word = '{flowInc, opNop, rNull};
			flowLdHLnn + 7'd1:  word = '{flowOp, opSma, rPC};
			flowLdHLnn + 7'd2:  word = '{flowOp, opNop, rNull};
			flowLdHLnn + 7'd3:  word = '{flowInc, opSrm, rL};
			flowLdHLnn + 7'd4:  word = '{flowOp, opSma, rPC};
			flowLdHLnn + 7'd5:  word = '{flowOp, opNop, rNull};
			flowLdHLnn + 7'd6:  word = '{flowIncEof, opSrm, rH};
			//////////////////////////////////////////////////
			// ALU flows
			flowIncB:           word = '{flowUpdateFlags, opInc16, rB};
			flowIncB + 7'd1:    word = '{flowIncEof, opNop, rNull};
			flowDecB:           word = '{flowUpdateFlags, opDec16, rB};
			flowDecB + 7'd1:    word = '{flowIncEof, opNop, rNull};
			flowAddAB:          word = '{flowOp, opSx16r, rA};
			flowAddAB + 7'd1:   word = '{flowUpdateFlags, opAddx16, rB};
			flowAddAB + 7'd2:   word = '{flowIncEof, opSrx16, rA};
			flowSubB:           word = '{flowOp, opSx16r, rA};
			flowSubB + 7'd1:    word = '{flowUpdateFlags, opSubx16, rB};
			flowSubB + 7'd2:    word = '{flowIncEof, opSrx16, rA};
			//////////////////////////////////////////////////
			// Memory through HL
			flowLdHLmA:         word = '{flowOp, opSma, rHL};
			flowLdHLmA + 7'd1:  word = '{flowIncEof, opSmw, rA};
			flowLdHLmB:         word = '{flowOp, opSma, rHL};
			flowLdHLmB + 7'd1:  word = '{flowIncEof, opSmw, rB};
			flowLdAHLm:         word = '{flowOp, opSma, rHL};
			flowLdAHLm + 7'd1:  word = '{flowOp, opNop, rNull};
			flowLdAHLm + 7'd2:  word = '{flowIncEof, opSrm, rA};
			//////////////////////////////////////////////////
			// Relative jumps, target is next PC plus signed x8
			flowJr:             word = '{flowInc, opNop, rNull};
			flowJr + 7'd1:      word = '{flowOp, opSma, rPC};
			flowJr + 7'd2:      word = '{flowOp, opNop, rNull};
			flowJr + 7'd3:      word = '{flowInc, opSrm, rX8};
			flowJr + 7'd4:      word = '{flowOp, opSx16r, rPC};
			flowJr + 7'd5:      word = '{flowOp, opAddx16, rX8};
			flowJr + 7'd6:      word = '{flowEof, opSpc, rX16};
			flowJrNz:           word = '{flowInc, opNop, rNull};
			flowJrNz + 7'd1:    word = '{flowOp, opSma, rPC};
			flowJrNz + 7'd2:    word = '{flowOp, opNop, rNull};
			flowJrNz + 7'd3:    word = '{flowIncEofZ, opSrm, rX8};
			flowJrNz + 7'd4:    word = '{flowOp, opSx16r, rPC};
			flowJrNz + 7'd5:    word = '{flowOp, opAddx16, rX8};
			flowJrNz + 7'd6:    word = '{flowEof, opSpc, rX16};
			flowJrZ:            word = '{flowInc, opNop, rNull};
			flowJrZ + 7'd1:     word = '{flowOp, opSma, rPC};
			flowJrZ + 7'd2:     word = '{flowOp, opNop, rNull};
			flowJrZ + 7'd3:     word = '{flowIncEofNz, opSrm, rX8};
			flowJrZ + 7'd4:     word = '{flowOp, opSx16r, rPC};
			flowJrZ + 7'd5:     word = '{flowOp, opAddx16, rX8};
			flowJrZ + 7'd6:     word = '{flowEof, opSpc, rX16};
			default:            word = '{flowOp, opNop, rNull};
		endcase
	end

	assign flow    = word.flow;
	assign op      = word.op;
	assign operand = word.operand;

endmodule

//--- verilog/dzcpuSequencer.sv
`timescale 1ns/1ps

module dzcpuSequencer
	import dzcpuPkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic [DataWidth-1:0] memRdData,
	dzcpuUopIf.seq               uop
);

	seqState_t             state;
	logic                  dispatch;
	logic [UaddrWidth-1:0] upc;
	logic [UaddrWidth-1:0] flowStart;
	logic [UaddrWidth-1:0] curUpc;
	uFlow_t                romFlow;
	uOp_t                  romOp;
	uOperand_t             romOperand;
	logic                  endOfFlow;

	dzcpuOpcodeLut i_lut
	(
		.opcode    (memRdData),
		.flowStart (flowStart)
	);

	// Opcode byte arrives in the first execute cycle
	assign curUpc = dispatch ? flowStart : upc;

	dzcpuUcodeRom i_rom
	(
		.addr    (curUpc),
		.flow    (romFlow),
		.op      (romOp),
		.operand (romOperand)
	);

	always_comb
	begin
		case (romFlow)
			flowEof,
			flowIncEof:   endOfFlow = 1'b1;
			flowIncEofZ:  endOfFlow = uop.flagZ;
			flowIncEofNz: endOfFlow = !uop.flagZ;
			default:      endOfFlow = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state    <= seqFetch;
			dispatch <= 1'b0;
			upc      <= '0;
		end
		else
		begin
			dispatch <= (state == seqFetch);
			upc      <= curUpc + 1'b1;
			case (state)
				seqFetch: state <= seqExec;
				seqExec:
				begin
					if (endOfFlow)
						state <= seqFetch;
				end
				default:  state <= seqFetch;
			endcase
		end
	end

	assign uop.flow    = romFlow;
	assign uop.op      = romOp;
	assign uop.operand = romOperand;
	assign uop.exec    = (state == seqExec);
	assign uop.fetch   = (state == seqFetch);

endmodule

//--- verilog/dzcpuDatapath.sv
`timescale 1ns/1ps

module dzcpuDatapath
	import dzcpuPkg::*;
#(
	parameter int DataWidth = 8,
	parameter int AddrWidth = 16
)
(
	input  logic                 clock,
	input  logic                 rst,
	dzcpuUopIf.dp                uop,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWrData,
	output logic                 memWe,
	input  logic [DataWidth-1:0] memRdData
);

	localparam int ExtWidth = AddrWidth - DataWidth;

	logic [DataWidth-1:0] regA, regB, regC, regH, regL, regX8;
	logic [AddrWidth-1:0] regX16;
	logic [AddrWidth-1:0] pc;
	logic [AddrWidth-1:0] addrReg;
	logic                 flagZ;
	logic                 flagC;

	logic [AddrWidth-1:0] opVal;
	logic [AddrWidth-1:0] aluResult;
	logic [AddrWidth-1:0] wrVal;
	uOperand_t            wrDest;
	logic                 wrEn;
	logic                 pcInc;

	//////////////////////////////////////////////////
	// Operand read and ALU

	always_comb
	begin
		case (uop.operand)
			rA:      opVal = {{ExtWidth{1'b0}}, regA};
			rB:      opVal = {{ExtWidth{1'b0}}, regB};
			rC:      opVal = {{ExtWidth{1'b0}}, regC};
			rH:      opVal = {{ExtWidth{1'b0}}, regH};
			rL:      opVal = {{ExtWidth{1'b0}}, regL};
			rHL:     opVal = {regH, regL};
			rPC:     opVal = pc;
			// Relative jump offset is signed
			rX8:     opVal = {{ExtWidth{regX8[DataWidth-1]}}, regX8};
			rX16:    opVal = regX16;
			default: opVal = '0;
		endcase
	end

	always_comb
	begin
		case (uop.op)
			opAddx16: aluResult = regX16 + opVal;
			opSubx16: aluResult = regX16 - opVal;
			opInc16:  aluResult = opVal + 1'b1;
			opDec16:  aluResult = opVal - 1'b1;
			default:  aluResult = opVal;
		endcase
	end

	// Destination and value for the register write
	always_comb
	begin
		wrEn   = 1'b1;
		wrDest = uop.operand;
		wrVal  = aluResult;
		case (uop.op)
			opSrm:    wrVal = {{ExtWidth{1'b0}}, memRdData};
			opSrx16:  wrVal = regX16;
			opInc16,
			opDec16:  wrVal = aluResult;
			opAddx16,
			opSubx16,
			opSx16r:  wrDest = rX16;
			opSpc:    wrDest = rPC;
			default:  wrEn = 1'b0;
		endcase
	end

	assign pcInc = uop.flow inside {flowInc, flowIncEof, flowIncEofZ, flowIncEofNz};

	//////////////////////////////////////////////////
	// Registers

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pc      <= '0;
			addrReg <= '0;
			flagZ   <= 1'b0;
			flagC   <= 1'b0;
		end
		else if (uop.exec)
		begin
			if (pcInc)
				pc <= pc + 1'b1;
			if (wrEn && wrDest == rPC)
				pc <= wrVal;
			if (uop.op == opSma)
				addrReg <= opVal;
			if (uop.flow == flowUpdateFlags)
			begin
				flagZ <= (aluResult[DataWidth-1:0] == '0);
				flagC <= aluResult[DataWidth];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (uop.exec && wrEn)
		begin
			case (wrDest)
				rA:      regA <= wrVal[DataWidth-1:0];
				rB:      regB <= wrVal[DataWidth-1:0];
				rC:      regC <= wrVal[DataWidth-1:0];
				rH:      regH <= wrVal[DataWidth-1:0];
				rL:      regL <= wrVal[DataWidth-1:0];
				rHL:     {regH, regL} <= wrVal;
				rX8:     regX8 <= wrVal[DataWidth-1:0];
				rX16:    regX16 <= wrVal;
				default: ;
			endcase
		end
	end

	// PC goes out during fetch
	assign memAddr   = uop.fetch ? pc : addrReg;
	assign memWrData = opVal[DataWidth-1:0];
	assign memWe     = uop.exec && (uop.op == opSmw);
	assign uop.flagZ = flagZ;

endmodule

//--- verilog/dzcpuTop.sv
`timescale 1ns/1ps

module dzcpuTop
	import dzcpuPkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWrData,
	output logic                 memWe,
	input  logic [DataWidth-1:0] memRdData
);

	// Micro-op and status between the two halves
	dzcpuUopIf i_uopIf ();

	dzcpuSequencer i_seq
	(
		.clock     (clock),
		.rst       (rst),
		.memRdData (memRdData),
		.uop       (i_uopIf)
	);

	dzcpuDatapath
	#(
		.DataWidth (DataWidth),
		.AddrWidth (AddrWidth)
	)
	i_dp
	(
		.clock     (clock),
		.rst       (rst),
		.uop       (i_uopIf),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memWe     (memWe),
		.memRdData (memRdData)
	);

endmodule

//--- testbench/dzcpu_checker.sv
`timescale 1ns/1ps

module dzcpuChecker
	import dzcpuPkg::*;
(
	input logic                 clock,
	input logic                 rst,
	input logic [AddrWidth-1:0] memAddr,
	input logic [DataWidth-1:0] memWrData,
	input logic                 memWe
);

	// Sequencer sits in fetch once reset has been seen on an edge
	weLowInReset: assert property (@(posedge clock) (rst && $past(rst)) |-> !memWe)
		else $error("memWe high while rst is high");

	weSinglePulse: assert property (@(posedge clock) disable iff (rst) memWe |=> !memWe)
		else $error("memWe high on two cycles in a row");

	writeKnown: assert property (@(posedge clock) disable iff (rst)
		memWe |-> (!$isunknown(memAddr) && !$isunknown(memWrData)))
		else $error("memAddr or memWrData unknown during a write");

endmodule

bind dzcpuTop dzcpuChecker i_checker
(
	.clock     (clock),
	.rst       (rst),
	.memAddr   (memAddr),
	.memWrData (memWrData),
	.memWe     (memWe)
);

//--- testbench/dzcpuTb.sv
`timescale 1ns/1ps

module dzcpuTb
	import dzcpuPkg::*;
();

	// Expected run length, straight-line part and one pass of the B loop
	localparam int StraightCycles = 200;
	localparam int LoopCycles     = 14;

	logic                 clock;
	logic                 rst;
	logic [AddrWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWrData;
	logic                 memWe;
	logic [DataWidth-1:0] memRdData;

	logic [7:0]  mem [0:255];
	int          writeCount [0:255];
	logic [7:0]  rdAddr;
	logic [7:0]  progPtr;
	logic [15:0] lfsrState;
	logic [7:0]  n1;
	logic [7:0]  n2;
	logic [7:0]  n3;
	logic [7:0]  expectSum;
	int          cycleCount   = 0;
	int          cycleLimit   = 0;
	int          errorCount   = 0;
	int          errorsBefore = 0;
	int          testsRun     = 0;
	int          testsFailed  = 0;
	int          totalWrites;

	dzcpuTop i_dut
	(
		.clock     (clock),
		.rst       (rst),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memWe     (memWe),
		.memRdData (memRdData)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Memory model with one cycle read latency

	always @(posedge clock)
	begin
		if (memWe)
		begin
			mem[memAddr[7:0]] = memWrData;
			writeCount[memAddr[7:0]] = writeCount[memAddr[7:0]] + 1;
		end
		rdAddr = memAddr[7:0];
		#1;
		memRdData = mem[rdAddr];
	end

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the program did not finish within %0d cycles", cycleLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		logic [15:0] stepped;
		stepped = state >> 1;
		if (state[0])
			stepped = stepped ^ 16'hB400;
		return stepped;
	endfunction

	// One LFSR step per bit
	task automatic nextRandomByte(output logic [7:0] value);
		value = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	// Bytes are left aligned, count of them taken from the top
	task automatic putBytes(input int count, input logic [23:0] bytes);
		logic [23:0] rest;
		rest = bytes;
		for (int i = 0; i < count; i++)
		begin
			mem[progPtr] = rest[23:16];
			progPtr = progPtr + 8'd1;
			rest = rest << 8;
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 256; i++)
		begin
			mem[i[7:0]] = 8'h00;
			writeCount[i[7:0]] = 0;
		end
		progPtr = 8'h00;
		// n1 to 0x80
		putBytes(3, {8'h21, 8'h80, 8'h00});
		putBytes(2, {8'h3E, n1, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		// Sum to 0x81, difference to 0x82
		putBytes(2, {8'h06, n2, 8'h00});
		putBytes(1, {8'h80, 16'h0000});
		putBytes(3, {8'h21, 8'h81, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		putBytes(1, {8'h90, 16'h0000});
		putBytes(3, {8'h21, 8'h82, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		// B counts down from n3, each pass stores B at 0x83
		putBytes(2, {8'h06, n3, 8'h00});
		putBytes(2, {8'h0E, 8'h00, 8'h00});
		putBytes(3, {8'h21, 8'h83, 8'h00});
		putBytes(1, {8'h70, 16'h0000});
		putBytes(1, {8'h05, 16'h0000});
		putBytes(2, {8'h20, 8'hFC, 8'h00});   // JR NZ back to the store
		putBytes(3, {8'h21, 8'h84, 8'h00});
		putBytes(1, {8'h70, 16'h0000});
		putBytes(1, {8'h04, 16'h0000});
		putBytes(3, {8'h21, 8'h85, 8'h00});
		putBytes(1, {8'h70, 16'h0000});
		// Zero result, JR Z jumps over the store to 0x86
		putBytes(3, {8'h21, 8'h86, 8'h00});
		putBytes(2, {8'h3E, 8'h01, 8'h00});
		putBytes(1, {8'h90, 16'h0000});
		putBytes(2, {8'h28, 8'h03, 8'h00});
		putBytes(2, {8'h3E, 8'hEE, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		// Nonzero result, JR Z falls through to the store to 0x87
		putBytes(3, {8'h21, 8'h87, 8'h00});
		putBytes(2, {8'h3E, 8'h02, 8'h00});
		putBytes(1, {8'h90, 16'h0000});
		putBytes(2, {8'h28, 8'h03, 8'h00});
		putBytes(2, {8'h3E, 8'hEE, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		// Copy 0x80 to 0x88 through A
		putBytes(3, {8'h21, 8'h80, 8'h00});
		putBytes(1, {8'h7E, 16'h0000});
		putBytes(3, {8'h21, 8'h88, 8'h00});
		putBytes(1, {8'h77, 16'h0000});
		// Undefined opcode 0xD3 just before the store to 0x89
		putBytes(3, {8'h21, 8'h89, 8'h00});
		putBytes(2, {8'h3E, n2, 8'h00});
		putBytes(1, {8'hD3, 16'h0000});
		putBytes(1, {8'h77, 16'h0000});
		// Park on JR -2
		putBytes(2, {8'h18, 8'hFE, 8'h00});
	endtask

	task automatic waitForStore(input logic [7:0] addr);
		logic seen;
		seen = 1'b0;
		while (!seen)
		begin
			@(posedge clock);
			seen = memWe && (memAddr == {8'h00, addr});
		end
		@(negedge clock);
	endtask

	task automatic checkByte(input logic [7:0] addr, input logic [7:0] expected,
		input string what);
		assert (mem[addr] === expected)
		else
		begin
			$display("ERROR at time %0t: %s, mem[0x%02h] is 0x%02h, expected 0x%02h",
				$time, what, addr, mem[addr], expected);
			errorCount = errorCount + 1;
		end
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		assert (actual == expected)
		else
		begin
			$display("ERROR at time %0t: %s, counted %0d, expected %0d",
				$time, what, actual, expected);
			errorCount = errorCount + 1;
		end
	endtask

	task automatic reportTest(input string name);
		testsRun = testsRun + 1;
		if (errorCount == errorsBefore)
			$display("Test %0d %s: ok", testsRun, name);
		else
		begin
			testsFailed = testsFailed + 1;
			$display("Test %0d %s: failed", testsRun, name);
		end
		errorsBefore = errorCount;
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		clock     = 1'b0;
		rst       = 1'b1;
		memRdData = 8'h00;
		lfsrState = 16'd58779;
		nextRandomByte(n1);
		nextRandomByte(n2);
		nextRandomByte(n3);
		if (n3 == 8'h00)
			n3 = 8'h01;
		expectSum  = n1 + n2;
		cycleLimit = 3 * (StraightCycles + LoopCycles * int'(n3));
		loadProgram();

		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;

		waitForStore(8'h80);
		checkByte(8'h80, n1, "store of immediate A");
		reportTest("immediate loads and store");

		waitForStore(8'h82);
		checkByte(8'h81, expectSum, "ADD A,B result");
		checkByte(8'h82, n1, "SUB B result");
		reportTest("ADD and SUB");

		waitForStore(8'h85);
		checkByte(8'h83, 8'h01, "last B stored in the loop");
		checkCount(writeCount[8'h83], int'(n3), "loop passes");
		checkByte(8'h84, 8'h00, "B after the loop");
		checkByte(8'h85, 8'h01, "B after INC B");
		reportTest("INC, DEC and JR NZ loop");

		waitForStore(8'h87);
		checkByte(8'h86, 8'h00, "store skipped by JR Z");
		checkCount(writeCount[8'h86], 0, "writes to the skipped address");
		checkByte(8'h87, 8'hEE, "store after JR Z not taken");
		reportTest("JR Z");

		waitForStore(8'h88);
		checkByte(8'h88, n1, "copy through LD A,(HL)");
		reportTest("LD A,(HL)");

		waitForStore(8'h89);
		checkByte(8'h89, n2, "store after opcode 0xD3");
		// Idle loop must not write
		repeat (24) @(posedge clock);
		@(negedge clock);
		totalWrites = 0;
		for (int i = 0; i < 256; i++)
			totalWrites = totalWrites + writeCount[i[7:0]];
		checkCount(totalWrites, 8 + int'(n3), "memory writes in the whole run");
		reportTest("unknown opcode");

		$display("Tests run %0d, failed %0d, check errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tb.f
verilog/dzcpuPkg.sv
verilog/dzcpuUopIf.sv
verilog/dzcpuOpcodeLut.sv
verilog/dzcpuUcodeRom.sv
verilog/dzcpuSequencer.sv
verilog/dzcpuDatapath.sv
verilog/dzcpuTop.sv
testbench/dzcpu_checker.sv
testbench/dzcpuTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module dzcpuTb \
	-f tb.f -o dzcpuSim \
	&& ./obj_dir/dzcpuSim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
